// ==== Bender.yml ====
package:
  name: sdcard

sources:
  - hw/sd_pkg.sv
  - hw/sd_cmd_if.sv
  - hw/sd_cmd_engine.sv
  - hw/sd_data_rx.sv
  - hw/sd_reader.sv
  - hw/sdcard.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/sd_card_model.sv
      - tb/tb_sdcard.sv

// ==== hw/sd_cmd_engine.sv ====
////////////////////////////////////////
// shifts a 48-bit command with crc7 onto the command line
// and captures the 48-bit or 136-bit response
////////////////////////////////////////
`timescale 1ns/1ps

module sd_cmd_engine
  import sd_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sd_clk_rise_i,
  input  logic     sd_clk_fall_i,
  sd_cmd_if.engine cmd_bus,
  input  logic     sd_cmd_i,
  output logic     sd_cmd_o
);

  // sd clocks to wait for a response start bit
  localparam int unsigned RespTimeout = 64;

  typedef enum logic [1:0] {
    E_IDLE,
    E_SEND,
    E_WAIT,
    E_RECV
  } eng_state_e;

  eng_state_e  state;
  logic [47:0] frame;
  logic [6:0]  crc;
  logic [7:0]  cnt;
  logic        long_q;
  logic [46:0] rx;
  logic        tx_bit;

  // x^7 + x^3 + 1, one bit per call
  function automatic logic [6:0] crc7_step(logic [6:0] c, logic b);
    logic fb;
    fb = c[6] ^ b;
    return {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
  endfunction

  // 40 frame bits, then 7 crc bits, then the end bit
  always_comb begin
    if (cnt < 8'd40) begin
      tx_bit = frame[47];
    end else if (cnt < 8'd47) begin
      tx_bit = crc[6];
    end else begin
      tx_bit = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= E_IDLE;
      cnt          <= '0;
      sd_cmd_o     <= 1'b1;
      cmd_bus.busy <= 1'b0;
      cmd_bus.done <= 1'b0;
    end else begin
      cmd_bus.done <= 1'b0;
      case (state)
        E_IDLE: begin
          if (cmd_bus.start) begin
            // start bit, transmit bit, index, argument
            frame        <= {2'b01, cmd_bus.index, cmd_bus.arg, 8'h00};
            long_q       <= cmd_bus.long_resp;
            crc          <= '0;
            cnt          <= '0;
            cmd_bus.busy <= 1'b1;
            state        <= E_SEND;
          end
        end
        E_SEND: begin
          // line changes right after the sd clock falls
          if (sd_clk_fall_i) begin
            if (cnt == 8'd48) begin
              sd_cmd_o <= 1'b1;
              cnt      <= '0;
              state    <= E_WAIT;
            end else begin
              sd_cmd_o <= tx_bit;
              frame    <= frame << 1;
              if (cnt < 8'd40) begin
                crc <= crc7_step(crc, frame[47]);
              end else begin
                crc <= {crc[5:0], 1'b0};
              end
              cnt <= cnt + 8'd1;
            end
          end
        end
        E_WAIT: begin
          if (sd_clk_rise_i) begin
            if (!sd_cmd_i) begin
              // start bit seen, it counts as bit 0
              rx    <= {rx[45:0], sd_cmd_i};
              cnt   <= 8'd1;
              state <= E_RECV;
            end else if (cnt == 8'(RespTimeout - 1)) begin
              cmd_bus.timeout <= 1'b1;
              cmd_bus.done    <= 1'b1;
              cmd_bus.busy    <= 1'b0;
              state           <= E_IDLE;
            end else begin
              cnt <= cnt + 8'd1;
            end
          end
        end
        E_RECV: begin
          if (sd_clk_rise_i) begin
            if (cnt == (long_q ? 8'd135 : 8'd47)) begin
              // low 48 bits only, the upper part of a long answer drops out
              cmd_bus.resp    <= sd_resp_u'({rx, sd_cmd_i});
              cmd_bus.timeout <= 1'b0;
              cmd_bus.done    <= 1'b1;
              cmd_bus.busy    <= 1'b0;
              state           <= E_IDLE;
            end else begin
              rx  <= {rx[45:0], sd_cmd_i};
              cnt <= cnt + 8'd1;
            end
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  // the reader must wait for the previous command to finish
  assert property (@(posedge clk) disable iff (!rst_n) cmd_bus.start |-> !cmd_bus.busy);

endmodule

// ==== hw/sd_cmd_if.sv ====
////////////////////////////////////////
// one command request and its response
// between the reader and the command engine
////////////////////////////////////////
`timescale 1ns/1ps

interface sd_cmd_if
  import sd_pkg::*;
();
  // request, start is a single-cycle pulse
  logic        start;
  sd_cmd_idx_e index;
  logic [31:0] arg;
  logic        long_resp;
  // response, timeout is valid together with done
  logic        busy;
  logic        done;
  logic        timeout;
  sd_resp_u    resp;

  modport reader (output start, index, arg, long_resp, input busy, done, timeout, resp);
  modport engine (input start, index, arg, long_resp, output busy, done, timeout, resp);

endinterface

// ==== hw/sd_data_rx.sv ====
////////////////////////////////////////
// collects one 512-byte block from data line 0
// arm it before the block can start
////////////////////////////////////////
`timescale 1ns/1ps

module sd_data_rx
  import sd_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sd_clk_rise_i,
  input  logic       arm_i,
  input  logic       sd_dat0_i,
  output logic       out_en_o,
  output logic [8:0] out_addr_o,
  output logic [7:0] out_byte_o,
  output logic       done_o
);

  // crc16 plus the end bit, not checked
  localparam int unsigned TailBits = 17;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_WAIT,
    RX_DATA,
    RX_TAIL
  } rx_state_e;

  rx_state_e  state;
  logic [6:0] shift;
  logic [4:0] bit_cnt;
  logic [8:0] byte_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= RX_IDLE;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      out_en_o   <= 1'b0;
      out_addr_o <= '0;
      done_o     <= 1'b0;
    end else begin
      out_en_o <= 1'b0;
      done_o   <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (arm_i) begin
            state <= RX_WAIT;
          end
        end
        RX_WAIT: begin
          // low start bit opens the block
          if (sd_clk_rise_i && !sd_dat0_i) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            state    <= RX_DATA;
          end
        end
        RX_DATA: begin
          if (sd_clk_rise_i) begin
            // msb first
            shift <= {shift[5:0], sd_dat0_i};
            if (bit_cnt == 5'd7) begin
              out_byte_o <= {shift, sd_dat0_i};
              out_addr_o <= byte_cnt;
              out_en_o   <= 1'b1;
              byte_cnt   <= byte_cnt + 9'd1;
              bit_cnt    <= '0;
              if (byte_cnt == 9'(SD_SECTOR_BYTES - 1)) begin
                state <= RX_TAIL;
              end
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
            end
          end
        end
        RX_TAIL: begin
          if (sd_clk_rise_i) begin
            if (bit_cnt == 5'(TailBits - 1)) begin
              done_o <= 1'b1;
              state  <= RX_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
            end
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/sd_pkg.sv ====
////////////////////////////////////////
// shared codes and response views for the SD card sector reader
// imported by wildcard wherever a name below is needed
////////////////////////////////////////

package sd_pkg;

  // bytes in one sector and one CMD17 block
  localparam int unsigned SD_SECTOR_BYTES = 512;
  // echo pattern sent with CMD8
  localparam logic [7:0] SD_CHECK_PATTERN = 8'hAA;

  // command indices used by the start-up sequence and the read
  typedef enum logic [5:0] {
    CMD_GO_IDLE        = 6'd0,
    CMD_ALL_SEND_CID   = 6'd2,
    CMD_SEND_REL_ADDR  = 6'd3,
    CMD_SELECT_CARD    = 6'd7,
    CMD_SEND_IF_COND   = 6'd8,
    CMD_READ_SINGLE    = 6'd17,
    ACMD_SEND_OP_COND  = 6'd41,
    CMD_APP_CMD        = 6'd55
  } sd_cmd_idx_e;

  typedef enum logic [1:0] {
    CARD_UNKNOWN = 2'd0,
    CARD_SDV1    = 2'd1,
    CARD_SDV2    = 2'd2,
    CARD_SDHCV2  = 2'd3
  } sd_card_type_e;

  // reader phase, also shown on the status port
  typedef enum logic [3:0] {
    STAT_RESET  = 4'd0,
    STAT_POWER  = 4'd1,
    STAT_CMD0   = 4'd2,
    STAT_CMD8   = 4'd3,
    STAT_ACMD41 = 4'd4,
    STAT_CMD2   = 4'd5,
    STAT_CMD3   = 4'd6,
    STAT_CMD7   = 4'd7,
    STAT_READY  = 4'd8,
    STAT_READ   = 4'd9,
    STAT_ERROR  = 4'd10
  } sd_stat_e;

  // r7 layout, answer to CMD8
  typedef struct packed {
    logic [1:0]  start;
    logic [5:0]  index;
    logic [19:0] reserved;
    logic [3:0]  voltage;
    logic [7:0]  pattern;
    logic [7:0]  crc_end;
  } sd_r7_t;

  // r3 layout, answer to ACMD41
  typedef struct packed {
    logic [1:0]  start;
    logic [5:0]  reserved;
    // ocr bit 31, low while the card is still powering up
    logic        ready;
    logic        ccs;
    logic [29:0] ocr;
    logic [7:0]  fill;
  } sd_r3_t;

  typedef union packed {
    logic [47:0] raw;
    sd_r7_t      r7;
    sd_r3_t      r3;
  } sd_resp_u;

endpackage

// ==== hw/sd_reader.sv ====
////////////////////////////////////////
// sd clock divider, card start-up sequence and
// single-sector reads with CMD17
////////////////////////////////////////
`timescale 1ns/1ps

module sd_reader
  import sd_pkg::*;
#(
  parameter int unsigned ClockDivider = 2,
  parameter int unsigned Simulate     = 0
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          rstart_i,
  input  logic [31:0]   rsector_i,
  output logic          rbusy_o,
  output logic          rdone_o,
  output sd_stat_e      card_stat_o,
  output sd_card_type_e card_type_o,
  output logic          sd_clk_o,
  input  logic          sd_cmd_i,
  output logic          sd_cmd_o,
  input  logic          sd_dat0_i,
  output logic          outen_o,
  output logic [8:0]    outaddr_o,
  output logic [7:0]    outbyte_o
);

  // power-up clocks with the command line high
  localparam int unsigned PowerClocks = (Simulate != 0) ? 8 : 74;
  // sd clocks between ACMD41 polls
  localparam int unsigned PollGap = (Simulate != 0) ? 4 : 1000;
  localparam logic [ClockDivider-1:0] RiseAt = ClockDivider'((1 << (ClockDivider - 1)) - 1);
  localparam logic [ClockDivider-1:0] FallAt = '1;

  logic [ClockDivider-1:0] div_cnt;
  logic        sd_rise;
  logic        sd_fall;
  logic [6:0]  pu_cnt;
  logic [9:0]  gap_cnt;
  logic        pending;
  logic        app_cmd;
  logic [15:0] rca;
  logic        cmd_phase;
  logic        rx_arm;
  logic        rx_done;

  sd_cmd_if cmd_bus ();

  // sd clock is the divider msb, so it is low out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign sd_clk_o  = div_cnt[ClockDivider-1];
  assign sd_rise   = (div_cnt == RiseAt);
  assign sd_fall   = (div_cnt == FallAt);
  assign rbusy_o   = (card_stat_o != STAT_READY);
  assign cmd_phase = card_stat_o inside {STAT_CMD0, STAT_CMD8, STAT_ACMD41,
                                         STAT_CMD2, STAT_CMD3, STAT_CMD7};

  // command for the current phase, taken by the engine on start
  always_comb begin
    cmd_bus.index     = CMD_GO_IDLE;
    cmd_bus.arg       = 32'h0;
    cmd_bus.long_resp = 1'b0;
    case (card_stat_o)
      STAT_CMD8: begin
        cmd_bus.index = CMD_SEND_IF_COND;
        cmd_bus.arg   = {20'h0, 4'h1, SD_CHECK_PATTERN};
      end
      STAT_ACMD41: begin
        if (app_cmd) begin
          // hcs only when CMD8 was answered
          cmd_bus.index = ACMD_SEND_OP_COND;
          cmd_bus.arg   = {1'b0, card_type_o == CARD_SDV2, 6'h0, 24'hFF8000};
        end else begin
          cmd_bus.index = CMD_APP_CMD;
          cmd_bus.arg   = {rca, 16'h0};
        end
      end
      STAT_CMD2: begin
        cmd_bus.index     = CMD_ALL_SEND_CID;
        cmd_bus.long_resp = 1'b1;
      end
      STAT_CMD3: cmd_bus.index = CMD_SEND_REL_ADDR;
      STAT_CMD7: begin
        cmd_bus.index = CMD_SELECT_CARD;
        cmd_bus.arg   = {rca, 16'h0};
      end
      STAT_READ: begin
        // block address for sdhc, byte address otherwise
        cmd_bus.index = CMD_READ_SINGLE;
        cmd_bus.arg   = (card_type_o == CARD_SDHCV2) ? rsector_i : {rsector_i[22:0], 9'h0};
      end
      default: cmd_bus.index = CMD_GO_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      card_stat_o   <= STAT_RESET;
      card_type_o   <= CARD_UNKNOWN;
      pu_cnt        <= '0;
      gap_cnt       <= '0;
      pending       <= 1'b0;
      app_cmd       <= 1'b0;
      rca           <= '0;
      rx_arm        <= 1'b0;
      rdone_o       <= 1'b0;
      cmd_bus.start <= 1'b0;
    end else begin
      cmd_bus.start <= 1'b0;
      rx_arm        <= 1'b0;
      rdone_o       <= 1'b0;
      if (gap_cnt != '0 && sd_rise) begin
        gap_cnt <= gap_cnt - 10'd1;
      end

      if (card_stat_o == STAT_RESET) begin
        card_stat_o <= STAT_POWER;
      end else if (card_stat_o == STAT_POWER) begin
        if (sd_rise) begin
          if (pu_cnt == 7'(PowerClocks - 1)) begin
            card_stat_o <= STAT_CMD0;
          end else begin
            pu_cnt <= pu_cnt + 7'd1;
          end
        end
      end else if (card_stat_o == STAT_READY) begin
        if (rstart_i) begin
          // receiver must be armed before the block can arrive
          rx_arm        <= 1'b1;
          cmd_bus.start <= 1'b1;
          pending       <= 1'b1;
          card_stat_o   <= STAT_READ;
        end
      end else if (pending) begin
        if (cmd_bus.done) begin
          pending <= 1'b0;
          case (card_stat_o)
            // CMD0 has no answer, the timeout is expected
            STAT_CMD0: card_stat_o <= STAT_CMD8;
            STAT_CMD8: begin
              if (cmd_bus.timeout) begin
                // v1 cards ignore CMD8
                card_type_o <= CARD_SDV1;
                card_stat_o <= STAT_ACMD41;
              end else if (cmd_bus.resp.r7.pattern == SD_CHECK_PATTERN &&
                           cmd_bus.resp.r7.voltage == 4'h1) begin
                card_type_o <= CARD_SDV2;
                card_stat_o <= STAT_ACMD41;
              end else begin
                card_stat_o <= STAT_ERROR;
              end
            end
            STAT_ACMD41: begin
              if (cmd_bus.timeout) begin
                card_stat_o <= STAT_ERROR;
              end else if (!app_cmd) begin
                app_cmd <= 1'b1;
              end else begin
                app_cmd <= 1'b0;
                if (cmd_bus.resp.r3.ready) begin
                  if (cmd_bus.resp.r3.ccs && card_type_o == CARD_SDV2) begin
                    card_type_o <= CARD_SDHCV2;
                  end
                  card_stat_o <= STAT_CMD2;
                end else begin
                  // still powering up, poll again later
                  gap_cnt <= 10'(PollGap);
                end
              end
            end
            STAT_CMD2: card_stat_o <= cmd_bus.timeout ? STAT_ERROR : STAT_CMD3;
            STAT_CMD3: begin
              // r6 carries the new rca right after the index
              rca         <= cmd_bus.resp.raw[39:24];
              card_stat_o <= cmd_bus.timeout ? STAT_ERROR : STAT_CMD7;
            end
            STAT_CMD7: card_stat_o <= cmd_bus.timeout ? STAT_ERROR : STAT_READY;
            STAT_READ: begin
              if (cmd_bus.timeout) begin
                card_stat_o <= STAT_ERROR;
              end
            end
            default: card_stat_o <= STAT_ERROR;
          endcase
        end
      end else if (card_stat_o == STAT_READ) begin
        if (rx_done) begin
          rdone_o     <= 1'b1;
          card_stat_o <= STAT_READY;
        end
      end else if (cmd_phase && !cmd_bus.busy && gap_cnt == '0) begin
        cmd_bus.start <= 1'b1;
        pending       <= 1'b1;
      end
    end
  end

  sd_cmd_engine i_cmd_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .sd_clk_rise_i(sd_rise),
    .sd_clk_fall_i(sd_fall),
    .cmd_bus      (cmd_bus),
    .sd_cmd_i     (sd_cmd_i),
    .sd_cmd_o     (sd_cmd_o)
  );

  sd_data_rx i_data_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .sd_clk_rise_i(sd_rise),
    .arm_i        (rx_arm),
    .sd_dat0_i    (sd_dat0_i),
    .out_en_o     (outen_o),
    .out_addr_o   (outaddr_o),
    .out_byte_o   (outbyte_o),
    .done_o       (rx_done)
  );

  // the host side may only start a read once the reader is free
  assert property (@(posedge clk) disable iff (!rst_n) rstart_i |-> !rbusy_o);

endmodule

// ==== hw/sdcard.sv ====
////////////////////////////////////////
// SD card sector reader with a 512-byte buffer
// cmd 1 reads a sector, cmd 2 steps through its bytes
////////////////////////////////////////
`timescale 1ns/1ps

module sdcard
  import sd_pkg::*;
#(
  // sd clock is clk divided by 2 ** ClockDivider
  parameter int unsigned ClockDivider = 2,
  parameter int unsigned Simulate     = 0
) (
  input  logic        clk,
  input  logic        rst_n,
  // 0 idle, 1 read sector, 2 next byte
  input  logic [1:0]  cmd_i,
  input  logic [31:0] sector_address_i,
  output logic [7:0]  data_o,
  output logic        busy_o,
  output logic [3:0]  card_stat_o,
  output logic [1:0]  card_type_o,
  output logic        sd_clk_o,
  output logic        sd_mosi_o,
  input  logic        sd_miso_i,
  input  logic        sd_cmd_i
);

  typedef enum logic [1:0] {
    Init,
    Idle,
    ReadSDCard
  } state_e;

  state_e      state;
  logic [7:0]  buffer [SD_SECTOR_BYTES];
  logic [8:0]  buffer_index;
  logic        rd_rstart;
  logic [31:0] rd_rsector;
  logic        rd_rbusy;
  logic        rd_rdone;
  logic        rd_outen;
  logic [8:0]  rd_outaddr;
  logic [7:0]  rd_outbyte;

  // byte at the host index, no register in between
  assign data_o = buffer[buffer_index];

  // the receiver supplies the address of every byte
  always_ff @(posedge clk) begin
    if (rd_outen) begin
      buffer[rd_outaddr] <= rd_outbyte;
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle && cmd_i == 2'd1) begin
      rd_rsector <= sector_address_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= Init;
      buffer_index <= '0;
      rd_rstart    <= 1'b0;
      // busy through card start-up
      busy_o       <= 1'b1;
    end else begin
      rd_rstart <= 1'b0;
      case (state)
        Init: begin
          if (!rd_rbusy) begin
            busy_o <= 1'b0;
            state  <= Idle;
          end
        end
        Idle: begin
          if (cmd_i == 2'd1) begin
            rd_rstart    <= 1'b1;
            buffer_index <= '0;
            busy_o       <= 1'b1;
            state        <= ReadSDCard;
          end else if (cmd_i == 2'd2) begin
            // wraps from 511 to 0
            buffer_index <= buffer_index + 9'd1;
          end
        end
        ReadSDCard: begin
          // host commands are ignored until the block is in
          if (rd_rdone) begin
            busy_o <= 1'b0;
            state  <= Idle;
          end
        end
        default: state <= Init;
      endcase
    end
  end

  sd_reader #(
    .ClockDivider(ClockDivider),
    .Simulate    (Simulate)
  ) i_sd_reader (
    .clk        (clk),
    .rst_n      (rst_n),
    .rstart_i   (rd_rstart),
    .rsector_i  (rd_rsector),
    .rbusy_o    (rd_rbusy),
    .rdone_o    (rd_rdone),
    .card_stat_o(card_stat_o),
    .card_type_o(card_type_o),
    .sd_clk_o   (sd_clk_o),
    .sd_cmd_i   (sd_cmd_i),
    .sd_cmd_o   (sd_mosi_o),
    .sd_dat0_i  (sd_miso_i),
    .outen_o    (rd_outen),
    .outaddr_o  (rd_outaddr),
    .outbyte_o  (rd_outbyte)
  );

  // sector bytes only arrive for a read the host asked for
  assert property (@(posedge clk) disable iff (!rst_n) rd_outen |-> state == ReadSDCard);

endmodule

// ==== sdcard.f ====
hw/sd_pkg.sv
hw/sd_cmd_if.sv
hw/sd_cmd_engine.sv
hw/sd_data_rx.sv
hw/sd_reader.sv
hw/sdcard.sv
tb/tb_clk_gen.sv
tb/sd_card_model.sv
tb/tb_sdcard.sv

// ==== tb/sd_card_model.sv ====
////////////////////////////////////////
// behavioral SDHC card on the one-bit bus
// answers the start-up commands and CMD17 block reads
////////////////////////////////////////
`timescale 1ns/1ps

module sd_card_model
  import sd_pkg::*;
(
  input  logic sd_clk_i,
  input  logic cmd_i,
  output logic cmd_o,
  output logic dat0_o
);

  localparam logic [15:0] CardRca = 16'h1234;

  logic [5:0]  idx;
  logic [31:0] arg;
  int unsigned polls;
  // last command frame as received, start bit included
  logic [47:0] last_cmd;

  // host bits are taken on the rising sd clock
  task automatic get_command(output logic [5:0] index, output logic [31:0] argument);
    logic [47:0] f;
    int unsigned i;
    @(posedge sd_clk_i);
    while (cmd_i !== 1'b0) @(posedge sd_clk_i);
    // start bit already seen
    f = 48'h0;
    for (i = 1; i < 48; i++) begin
      @(posedge sd_clk_i);
      f = {f[46:0], cmd_i};
    end
    index    = f[45:40];
    argument = f[39:8];
    last_cmd = f;
  endtask

  // response msb first, changed on the falling sd clock after a short gap
  task automatic send_resp(input logic [135:0] bits, input int unsigned len);
    int unsigned i;
    repeat (2) @(negedge sd_clk_i);
    for (i = len; i > 0; i--) begin
      @(negedge sd_clk_i);
      cmd_o <= bits[i-1];
    end
  endtask

  // byte k of sector s is (s ^ k) + k[8], low bytes only
  task automatic send_block(input logic [31:0] blk);
    int unsigned k;
    int unsigned b;
    logic [8:0]  kk;
    logic [7:0]  v;
    @(negedge sd_clk_i);
    dat0_o <= 1'b0;
    for (k = 0; k < SD_SECTOR_BYTES; k++) begin
      kk = k[8:0];
      v  = (blk[7:0] ^ kk[7:0]) + {7'd0, kk[8]};
      for (b = 0; b < 8; b++) begin
        @(negedge sd_clk_i);
        dat0_o <= v[7-b];
      end
    end
    // crc16 left at zero, then the end bit
    repeat (16) begin
      @(negedge sd_clk_i);
      dat0_o <= 1'b0;
    end
    @(negedge sd_clk_i);
    dat0_o <= 1'b1;
  endtask

  initial begin
    cmd_o    = 1'b1;
    dat0_o   = 1'b1;
    polls    = 0;
    last_cmd = 48'h0;
    forever begin
      get_command(idx, arg);
      case (idx)
        CMD_SEND_IF_COND: send_resp({2'b00, 6'd8, 20'h0, arg[11:0], 8'h01}, 48);
        CMD_APP_CMD:      send_resp({2'b00, 6'd55, 32'h0000_0120, 8'h01}, 48);
        ACMD_SEND_OP_COND: begin
          // busy on the first two polls, then ready with ccs
          send_resp({2'b00, 6'h3F, polls >= 2, polls >= 2, 30'h00FF_8000, 8'hFF}, 48);
          polls = polls + 1;
        end
        CMD_ALL_SEND_CID: begin
          send_resp({2'b00, 6'h3F, 31'h0, 32'h0012_3456, 64'h5344_4331_3647_4231, 1'b1},
                    136);
        end
        CMD_SEND_REL_ADDR: send_resp({2'b00, 6'd3, CardRca, 16'h0500, 8'h01}, 48);
        CMD_SELECT_CARD:   send_resp({2'b00, 6'd7, 32'h0000_0700, 8'h01}, 48);
        CMD_READ_SINGLE: begin
          send_resp({2'b00, 6'd17, 32'h0000_0900, 8'h01}, 48);
          repeat (8) @(negedge sd_clk_i);
          // block address, the card is sdhc
          send_block(arg);
        end
        // CMD0 and anything unknown get no answer
        default: cmd_o <= 1'b1;
      endcase
    end
  end

endmodule

// ==== tb/tb_clk_gen.sv ====
////////////////////////////////////////
// testbench clock (40 ns) and reset held low for 16 cycles
////////////////////////////////////////
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned HalfPeriod  = 20,
  parameter int unsigned ResetCycles = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(HalfPeriod) clk = ~clk;
  end

  // release on a rising edge, like any other driven input
  initial begin
    rst_n = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb/tb_sdcard.sv ====
////////////////////////////////////////
// table-driven test of sdcard against the card model
// start-up, sector reads, byte stepping, commands while busy
////////////////////////////////////////
`timescale 1ns/1ps

module tb_sdcard
  import sd_pkg::*;
();

  localparam int unsigned NumEntries   = 5;
  localparam int unsigned NumRandom    = 3;
  localparam int unsigned StartupLimit = 40000;
  localparam int unsigned ReadLimit    = 20000;

  logic        clk;
  logic        rst_n;
  logic [1:0]  cmd;
  logic [31:0] sector_address;
  logic [7:0]  data;
  logic        busy;
  logic [3:0]  card_stat;
  logic [1:0]  card_type;
  logic        sd_clk;
  logic        sd_mosi;
  logic        sd_miso;
  logic        sd_cmd_ret;

  // host index and sector as the testbench expects them
  logic [8:0]  idx;
  logic [31:0] cur_sector;
  int unsigned checks   = 0;
  int unsigned errors   = 0;
  int unsigned timeouts = 0;

  tb_clk_gen i_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  sdcard #(
    .ClockDivider(1),
    .Simulate    (1)
  ) i_sdcard (
    .clk             (clk),
    .rst_n           (rst_n),
    .cmd_i           (cmd),
    .sector_address_i(sector_address),
    .data_o          (data),
    .busy_o          (busy),
    .card_stat_o     (card_stat),
    .card_type_o     (card_type),
    .sd_clk_o        (sd_clk),
    .sd_mosi_o       (sd_mosi),
    .sd_miso_i       (sd_miso),
    .sd_cmd_i        (sd_cmd_ret)
  );

  sd_card_model i_card (
    .sd_clk_i(sd_clk),
    .cmd_i   (sd_mosi),
    .cmd_o   (sd_cmd_ret),
    .dat0_o  (sd_miso)
  );

  // stimulus table
  // sector | poke while busy | four offsets walked in order, wrapping past 511
  function automatic logic [68:0] stim_entry(input int unsigned i);
    case (i)
      0:       return {32'h0000_0000, 1'b0, 9'd1, 9'd2, 9'd255, 9'd511};
      1:       return {32'h0000_0001, 1'b0, 9'd7, 9'd256, 9'd511, 9'd3};
      2:       return {32'h00AB_CDEF, 1'b1, 9'd16, 9'd300, 9'd510, 9'd511};
      3:       return {32'h0000_015A, 1'b0, 9'd511, 9'd0, 9'd1, 9'd64};
      default: return {32'hFFFF_FFFF, 1'b1, 9'd128, 9'd129, 9'd130, 9'd400};
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected byte k of sector s
  function automatic logic [7:0] sector_byte(input logic [31:0] s, input logic [8:0] k);
    return (s[7:0] ^ k[7:0]) + {7'd0, k[8]};
  endfunction

  // crc7 of start, transmit, index and argument
  function automatic logic [6:0] cmd_crc7(input logic [39:0] bits);
    logic [46:0] rem;
    int          i;
    rem = {bits, 7'h0};
    // long division by x^7 + x^3 + 1
    for (i = 46; i >= 7; i--) begin
      if (rem[i]) begin
        rem[i -: 8] = rem[i -: 8] ^ 8'h89;
      end
    end
    return rem[6:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // last frame the card took from the command line
  task automatic compare_last_command(input logic [5:0] index, input logic [31:0] arg);
    logic [47:0] f;
    f = i_card.last_cmd;
    check_value("sd_mosi_o command", f[46:40], {1'b1, index});
    check_value("sd_mosi_o argument", f[39:8], arg);
    check_value("sd_mosi_o crc7", f[7:1], cmd_crc7(f[47:8]));
    check_value("sd_mosi_o end bit", f[0], 1);
  endtask

  task automatic wait_for_reset();
    int unsigned n;
    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(posedge clk);
      n = n + 1;
    end
    if (rst_n !== 1'b1) begin
      timeouts = timeouts + 1;
      $display("Timeout: reset was never released");
    end
  endtask

  task automatic wait_busy_low(input int unsigned limit, input string what);
    int unsigned n;
    n = 0;
    while (busy !== 1'b0 && n < limit) begin
      @(negedge clk);
      n = n + 1;
    end
    if (busy !== 1'b0) begin
      timeouts = timeouts + 1;
      $display("Timeout: busy_o still high after %0d cycles of %s", limit, what);
    end
  endtask

  // command 1, optionally followed by commands 1 and 2 that must be ignored
  task automatic read_sector(input logic [31:0] sector, input logic poke);
    int unsigned j;
    @(posedge clk);
    cmd            <= 2'd1;
    sector_address <= sector;
    @(posedge clk);
    if (poke) begin
      for (j = 0; j < 8; j++) begin
        cmd            <= j[0] ? 2'd1 : 2'd2;
        sector_address <= ~sector;
        @(posedge clk);
      end
    end
    cmd <= 2'd0;
    @(negedge clk);
    check_value("busy_o", busy, 1);
    wait_busy_low(ReadLimit, "a sector read");
    cur_sector = sector;
    idx        = '0;
    if (timeouts == 0) begin
      check_value("data_o[0]", data, sector_byte(sector, 9'd0));
      // sdhc takes the sector number as the block address
      compare_last_command(CMD_READ_SINGLE, sector);
    end
  endtask

  // hold command 2 one cycle per step and check every byte passed
  task automatic step_to(input logic [8:0] target);
    int unsigned n;
    n = 0;
    if (idx != target) begin
      @(posedge clk);
      cmd <= 2'd2;
      while (idx != target && n < SD_SECTOR_BYTES) begin
        @(posedge clk);
        idx = idx + 9'd1;
        n   = n + 1;
        if (idx == target) begin
          cmd <= 2'd0;
        end
        @(negedge clk);
        check_value($sformatf("data_o[%0d]", idx), data, sector_byte(cur_sector, idx));
      end
    end
  endtask

  task automatic run_entry(input logic [31:0] sector, input logic poke,
                           input logic [35:0] offs);
    int unsigned j;
    read_sector(sector, poke);
    for (j = 0; j < 4 && timeouts == 0; j++) begin
      step_to(offs[35 - 9*j -: 9]);
    end
  endtask

  initial begin
    int unsigned i;
    logic [68:0] e;
    logic [31:0] rnd;
    cmd            = 2'd0;
    sector_address = 32'h0;
    idx            = '0;
    cur_sector     = 32'h0;

    wait_for_reset();
    @(negedge clk);
    check_value("busy_o", busy, 1);
    wait_busy_low(StartupLimit, "card start-up");
    if (timeouts == 0) begin
      check_value("card_type_o", card_type, 2'd3);
      check_value("card_stat_o", card_stat, STAT_READY);
      // start-up ends with CMD7 to the rca the card gave in CMD3
      compare_last_command(CMD_SELECT_CARD, {16'h1234, 16'h0});
    end

    for (i = 0; i < NumEntries && timeouts == 0; i++) begin
      e = stim_entry(i);
      run_entry(e[68:37], e[36], e[35:0]);
    end

    // random sectors, read back to back after the table
    rnd = 32'h6b99_0773;
    for (i = 0; i < NumRandom && timeouts == 0; i++) begin
      rnd = xorshift32(rnd);
      run_entry(rnd, rnd[31], {rnd[8:0], 9'd511, 9'd0, 9'd5});
    end

    $display("summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
